// File: logic/pipe_cfg.svh
// Pipeline widths
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// Width of a data word and of an instruction.
`define PIPE_DATA_W 32

// Number of general purpose registers.
`define PIPE_REG_COUNT 32

// Width of a register index field.
`define PIPE_REG_IDX_W 5

`endif

// File: logic/pipePkg.sv
// Pipeline encodings
package pipePkg;

    // Primary opcodes in bits 31:26.
    typedef enum logic [5:0]
    {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcodeE;

    // Function codes in bits 5:0 of SPECIAL instructions.
    typedef enum logic [5:0]
    {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } functE;

    typedef enum logic [3:0]
    {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,  // Signed compare.
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_LUI  = 4'd8,
        ALU_NONE = 4'd15  // Result is zero, used by bubbles and unknown encodings.
    } aluOpE;

endpackage

// File: logic/instrDecode.sv
// Instruction decoder
`include "pipe_cfg.svh"

module instrDecode import pipePkg::*;
(
    input  logic [`PIPE_DATA_W-1:0]    instr,
    output logic [`PIPE_REG_IDX_W-1:0] rs,
    output logic [`PIPE_REG_IDX_W-1:0] rt,
    output logic [`PIPE_REG_IDX_W-1:0] rd,
    output logic                       memToReg,
    output logic                       memWrite,
    output logic                       regWrite,
    output logic                       regDstRd,
    output logic                       aluSrcImm,
    output logic                       aluSrcShamt,
    output logic                       usesRt,
    output aluOpE                      aluOp,
    output logic [`PIPE_DATA_W-1:0]    immExt,
    output logic [4:0]                 shamt
);

    logic [5:0]  opField;
    logic [5:0]  fnField;
    logic [15:0] imm16;
    logic        zeroExt;

    assign opField = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign shamt   = instr[10:6];
    assign fnField = instr[5:0];
    assign imm16   = instr[15:0];

    // Logical immediates are zero extended, everything else is sign extended.
    assign immExt = zeroExt ? {{(`PIPE_DATA_W-16){1'b0}}, imm16}
                            : {{(`PIPE_DATA_W-16){imm16[15]}}, imm16};

    always_comb
    begin
        aluOp       = ALU_NONE;
        memToReg    = 1'b0;
        memWrite    = 1'b0;
        regWrite    = 1'b0;
        regDstRd    = 1'b0;
        aluSrcImm   = 1'b0;
        aluSrcShamt = 1'b0;
        usesRt      = 1'b0;
        zeroExt     = 1'b0;
        case (opField)
            OP_SPECIAL:
            begin
                case (fnField)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    default: aluOp = ALU_NONE;
                endcase
                aluSrcShamt = (aluOp == ALU_SLL) || (aluOp == ALU_SRL);
                regWrite    = (aluOp != ALU_NONE); // Unknown functions write nothing.
                regDstRd    = regWrite;
                usesRt      = regWrite;
            end
            OP_ADDIU: {aluOp, regWrite, aluSrcImm} = {ALU_ADD, 2'b11};
            OP_SLTI:  {aluOp, regWrite, aluSrcImm} = {ALU_SLT, 2'b11};
            OP_ANDI:  {aluOp, regWrite, aluSrcImm, zeroExt} = {ALU_AND, 3'b111};
            OP_ORI:   {aluOp, regWrite, aluSrcImm, zeroExt} = {ALU_OR, 3'b111};
            OP_LUI:   {aluOp, regWrite, aluSrcImm} = {ALU_LUI, 2'b11};
            OP_LW:    {aluOp, regWrite, aluSrcImm, memToReg} = {ALU_ADD, 3'b111};
            OP_SW:
            begin
                aluOp     = ALU_ADD;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                usesRt    = 1'b1; // The store data comes from rt.
            end
            default: aluOp = ALU_NONE;
        endcase
    end

endmodule

// File: logic/regFile.sv
// Register file
`include "pipe_cfg.svh"

module regFile
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`PIPE_REG_IDX_W-1:0] readReg1,
    input  logic [`PIPE_REG_IDX_W-1:0] readReg2,
    output logic [`PIPE_DATA_W-1:0]    readData1,
    output logic [`PIPE_DATA_W-1:0]    readData2,
    input  logic                       wbWrite,
    input  logic [`PIPE_REG_IDX_W-1:0] wbReg,
    input  logic [`PIPE_DATA_W-1:0]    wbData
);

    logic [`PIPE_DATA_W-1:0] regs [`PIPE_REG_COUNT];

    // Register zero reads as zero, and a same-cycle write is passed through.
    function automatic logic [`PIPE_DATA_W-1:0] readPort(
        input logic [`PIPE_REG_IDX_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (wbWrite && (wbReg == idx))
            return wbData;
        return regs[idx];
    endfunction

    always_comb
    begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `PIPE_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wbWrite && (wbReg != '0))
            regs[wbReg] <= wbData;
    end

    // A writeback to register zero must leave its storage untouched.
    zeroRegHeld: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

// File: logic/hazardUnit.sv
// Load-use hazard detection
`include "pipe_cfg.svh"

module hazardUnit
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`PIPE_REG_IDX_W-1:0] rs,
    input  logic [`PIPE_REG_IDX_W-1:0] rt,
    input  logic                       usesRt,
    input  logic                       memToRegE,
    input  logic [`PIPE_REG_IDX_W-1:0] rtE,
    output logic                       stall,
    output logic                       bubble
);

    logic rsMatch;
    logic rtMatch;

    assign rsMatch = (rtE == rs);
    assign rtMatch = usesRt && (rtE == rt);

    // A load in execute whose target is read in decode.
    assign stall  = memToRegE && (rtE != '0) && (rsMatch || rtMatch);
    assign bubble = stall; // The bubble retires the load's dependency in one cycle.

    // The bubble clears memToRegE, so a stall cannot repeat on the next cycle.
    singleCycleStall: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall);

endmodule

// File: logic/idExRegister.sv
// ID/EX pipeline register
`include "pipe_cfg.svh"

module idExRegister import pipePkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       bubble,
    input  logic                       memToReg,
    input  logic                       memWrite,
    input  logic                       regWrite,
    input  logic                       regDstRd,
    input  logic                       aluSrcImm,
    input  logic                       aluSrcShamt,
    input  pipePkg::aluOpE             aluOp,
    input  logic [`PIPE_DATA_W-1:0]    readData1,
    input  logic [`PIPE_DATA_W-1:0]    readData2,
    input  logic [`PIPE_DATA_W-1:0]    immExt,
    input  logic [4:0]                 shamt,
    input  logic [`PIPE_REG_IDX_W-1:0] rs,
    input  logic [`PIPE_REG_IDX_W-1:0] rt,
    input  logic [`PIPE_REG_IDX_W-1:0] rd,
    output logic                       memToRegE,
    output logic                       memWriteE,
    output logic                       regWriteE,
    output logic                       regDstRdE,
    output logic                       aluSrcImmE,
    output logic                       aluSrcShamtE,
    output pipePkg::aluOpE             aluOpE,
    output logic [`PIPE_DATA_W-1:0]    readData1E,
    output logic [`PIPE_DATA_W-1:0]    readData2E,
    output logic [`PIPE_DATA_W-1:0]    immExtE,
    output logic [4:0]                 shamtE,
    output logic [`PIPE_REG_IDX_W-1:0] rsE,
    output logic [`PIPE_REG_IDX_W-1:0] rtE,
    output logic [`PIPE_REG_IDX_W-1:0] rdE
);

    // Control fields and register indices; a bubble turns them into a no-op.
    always_ff @(posedge clk)
    begin
        if (reset || bubble)
        begin
            {memToRegE, memWriteE, regWriteE} <= 3'b000;
            {regDstRdE, aluSrcImmE, aluSrcShamtE} <= 3'b000;
            aluOpE <= ALU_NONE;
            rsE    <= '0;
            rtE    <= '0;
            rdE    <= '0;
        end
        else
        begin
            {memToRegE, memWriteE, regWriteE} <= {memToReg, memWrite, regWrite};
            {regDstRdE, aluSrcImmE, aluSrcShamtE} <= {regDstRd, aluSrcImm, aluSrcShamt};
            aluOpE <= aluOp;
            rsE    <= rs;
            rtE    <= rt;
            rdE    <= rd;
        end
    end

    always_ff @(posedge clk)
    begin
        readData1E <= readData1; // Payload is ignored whenever aluOpE is NONE.
        readData2E <= readData2;
        immExtE    <= immExt;
        shamtE     <= shamt;
    end

    // A bubble is only ever inserted behind a load, and it leaves nothing to write.
    bubbleNoWrite: assert property (@(posedge clk) disable iff (reset)
        bubble |-> memToRegE ##1 (!regWriteE && !memWriteE && !memToRegE));

endmodule

// File: logic/executeStage.sv
// Execute stage with ALU
`include "pipe_cfg.svh"

module executeStage import pipePkg::*;
(
    input  logic                       regDstRdE,
    input  logic                       aluSrcImmE,
    input  logic                       aluSrcShamtE,
    input  pipePkg::aluOpE             aluOpE,
    input  logic [`PIPE_DATA_W-1:0]    readData1E,
    input  logic [`PIPE_DATA_W-1:0]    readData2E,
    input  logic [`PIPE_DATA_W-1:0]    immExtE,
    input  logic [4:0]                 shamtE,
    input  logic [`PIPE_REG_IDX_W-1:0] rsE,
    input  logic [`PIPE_REG_IDX_W-1:0] rtE,
    input  logic [`PIPE_REG_IDX_W-1:0] rdE,
    input  logic                       wbWrite,
    input  logic [`PIPE_REG_IDX_W-1:0] wbReg,
    input  logic [`PIPE_DATA_W-1:0]    wbData,
    output logic [`PIPE_DATA_W-1:0]    aluResult,
    output logic [`PIPE_DATA_W-1:0]    storeData,
    output logic [`PIPE_REG_IDX_W-1:0] writeReg
);

    logic                    wbValid;
    logic [`PIPE_DATA_W-1:0] fwdA;
    logic [`PIPE_DATA_W-1:0] fwdB;
    logic [`PIPE_DATA_W-1:0] srcA;
    logic [`PIPE_DATA_W-1:0] srcB;

    assign wbValid = wbWrite && (wbReg != '0);

    assign fwdA = (wbValid && (wbReg == rsE)) ? wbData : readData1E;
    assign fwdB = (wbValid && (wbReg == rtE)) ? wbData : readData2E;

    assign storeData = fwdB;
    assign writeReg  = regDstRdE ? rdE : rtE;

    // Shifts take rt as the value and shamt as the distance.
    assign srcA = aluSrcShamtE ? fwdB : fwdA;

    always_comb
    begin
        if (aluSrcShamtE)
            srcB = {{(`PIPE_DATA_W-5){1'b0}}, shamtE};
        else if (aluSrcImmE)
            srcB = immExtE;
        else
            srcB = fwdB;
    end

    always_comb
    begin
        case (aluOpE)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            ALU_SLT: aluResult = {{(`PIPE_DATA_W-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLL: aluResult = srcA << srcB[4:0];
            ALU_SRL: aluResult = srcA >> srcB[4:0];
            ALU_LUI: aluResult = {srcB[15:0], 16'h0000};
            default: aluResult = '0; // NONE and bubbles.
        endcase
    end

endmodule

// File: logic/decodeExecute.sv
// Decode to execute pipeline slice
`include "pipe_cfg.svh"

module decodeExecute import pipePkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`PIPE_DATA_W-1:0]    instr,
    input  logic                       wbWrite,
    input  logic [`PIPE_REG_IDX_W-1:0] wbReg,
    input  logic [`PIPE_DATA_W-1:0]    wbData,
    output logic [`PIPE_DATA_W-1:0]    aluResult,
    output logic [`PIPE_DATA_W-1:0]    storeData,
    output logic [`PIPE_REG_IDX_W-1:0] writeReg,
    output logic                       regWrite,
    output logic                       memToReg,
    output logic                       memWrite,
    output logic                       stall
);

    logic [`PIPE_REG_IDX_W-1:0] rsD, rtD, rdD, rsE, rtE, rdE;
    logic                       memToRegD, memWriteD, regWriteD, regDstRdD;
    logic                       aluSrcImmD, aluSrcShamtD, usesRtD;
    logic                       regDstRdE, aluSrcImmE, aluSrcShamtE;
    aluOpE                      aluOpD, aluOpEx;
    logic [`PIPE_DATA_W-1:0]    immExtD, immExtE, readData1, readData2;
    logic [`PIPE_DATA_W-1:0]    readData1E, readData2E;
    logic [4:0]                 shamtD, shamtE;
    logic                       bubble;

    instrDecode i_decode (.instr, .rs(rsD), .rt(rtD), .rd(rdD), .memToReg(memToRegD),
        .memWrite(memWriteD), .regWrite(regWriteD), .regDstRd(regDstRdD),
        .aluSrcImm(aluSrcImmD), .aluSrcShamt(aluSrcShamtD), .usesRt(usesRtD),
        .aluOp(aluOpD), .immExt(immExtD), .shamt(shamtD));

    regFile i_regFile (.clk, .reset, .readReg1(rsD), .readReg2(rtD), .readData1,
        .readData2, .wbWrite, .wbReg, .wbData);

    hazardUnit i_hazard (.clk, .reset, .rs(rsD), .rt(rtD), .usesRt(usesRtD),
        .memToRegE(memToReg), .rtE, .stall, .bubble);

    idExRegister i_idEx (.clk, .reset, .bubble, .memToReg(memToRegD),
        .memWrite(memWriteD), .regWrite(regWriteD), .regDstRd(regDstRdD),
        .aluSrcImm(aluSrcImmD), .aluSrcShamt(aluSrcShamtD), .aluOp(aluOpD),
        .readData1, .readData2, .immExt(immExtD), .shamt(shamtD), .rs(rsD), .rt(rtD),
        .rd(rdD), .memToRegE(memToReg), .memWriteE(memWrite), .regWriteE(regWrite),
        .regDstRdE, .aluSrcImmE, .aluSrcShamtE, .aluOpE(aluOpEx), .readData1E,
        .readData2E, .immExtE, .shamtE, .rsE, .rtE, .rdE);

    executeStage i_execute (.regDstRdE, .aluSrcImmE, .aluSrcShamtE, .aluOpE(aluOpEx),
        .readData1E, .readData2E, .immExtE, .shamtE, .rsE, .rtE, .rdE, .wbWrite,
        .wbReg, .wbData, .aluResult, .storeData, .writeReg);

endmodule

// File: testbench/decodeExecuteTb.sv
// Decode to execute testbench
`include "pipe_cfg.svh"

module decodeExecuteTb import pipePkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS    = 27;
    localparam int CYCLE_LIMIT = NUM_ROWS * 2 + 20;
    localparam logic [`PIPE_DATA_W-1:0] NOP = 32'hFC00_0000; // Unknown opcode, rt is zero.

    // Expected control levels as {regWrite, memWrite, memToReg}.
    localparam logic [2:0] NO = 3'b000;
    localparam logic [2:0] WR = 3'b100;
    localparam logic [2:0] ST = 3'b010;
    localparam logic [2:0] LD = 3'b101;

    // One row per clock cycle. The expected fields describe the execute outputs of that
    // cycle, which belong to the instruction of the row before.
    typedef struct packed
    {
        logic [`PIPE_DATA_W-1:0]    instr;
        logic                       wbWrite;
        logic [`PIPE_REG_IDX_W-1:0] wbReg;
        logic [`PIPE_DATA_W-1:0]    wbData;
        logic [`PIPE_DATA_W-1:0]    expAlu;
        logic [`PIPE_REG_IDX_W-1:0] expWriteReg;
        logic [2:0]                 expCtrl;
        logic                       expStall;
        logic                       checkStore;
        logic [`PIPE_DATA_W-1:0]    expStore;
    } rowT;

    logic                       clk;
    logic                       reset;
    logic [`PIPE_DATA_W-1:0]    instr;
    logic                       wbWrite;
    logic [`PIPE_REG_IDX_W-1:0] wbReg;
    logic [`PIPE_DATA_W-1:0]    wbData;
    logic [`PIPE_DATA_W-1:0]    aluResult;
    logic [`PIPE_DATA_W-1:0]    storeData;
    logic [`PIPE_REG_IDX_W-1:0] writeReg;
    logic                       regWrite;
    logic                       memToReg;
    logic                       memWrite;
    logic                       stall;

    rowT                     rows [NUM_ROWS];
    int                      rowCount = 0;
    int                      cycles = 0;
    logic                    holdInstr = 1'b0;
    logic [`PIPE_DATA_W-1:0] a, b, c, d, e, f;

    decodeExecute i_dut (.clk, .reset, .instr, .wbWrite, .wbReg, .wbData, .aluResult,
        .storeData, .writeReg, .regWrite, .memToReg, .memWrite, .stall);

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            failRun("The run did not finish within the cycle limit.");
    end

    task automatic failRun(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic checkValue(input int row, input string name,
        input logic [`PIPE_DATA_W-1:0] expected, input logic [`PIPE_DATA_W-1:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Error: row %0d %s expected 0x%h actual 0x%h", row, name, expected, actual);
            failRun("An output did not match its expected value.");
        end
    endtask

    function automatic logic [`PIPE_DATA_W-1:0] rType(input functE fn,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [`PIPE_DATA_W-1:0] iType(input opcodeE op,
        input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [`PIPE_DATA_W-1:0] signedLess(input logic [`PIPE_DATA_W-1:0] x,
        input logic [`PIPE_DATA_W-1:0] y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    task automatic addRow(input logic [`PIPE_DATA_W-1:0] instrIn, input logic wbW,
        input logic [4:0] wbR, input logic [`PIPE_DATA_W-1:0] wbD,
        input logic [`PIPE_DATA_W-1:0] alu, input logic [4:0] dest, input logic [2:0] ctrl,
        input logic stallIn);
        if (rowCount >= NUM_ROWS)
            failRun("The stimulus table has more rows than it can hold.");
        rows[rowCount] = {instrIn, wbW, wbR, wbD, alu, dest, ctrl, stallIn, 1'b0, 32'h0};
        rowCount++;
    endtask

    // Adds a storeData check to the last row.
    task automatic expectStore(input logic [`PIPE_DATA_W-1:0] data);
        rows[rowCount-1].checkStore = 1'b1;
        rows[rowCount-1].expStore   = data;
    endtask

    task automatic buildTable();
        addRow(rType(FN_ADDU, 5'd5, 5'd6, 5'd7, 5'd0), 1'b0, 5'd0, 32'h0, 32'h0, 5'd0, NO, 1'b0);
        addRow(NOP, 1'b1, 5'd1, a, 32'h0, 5'd7, WR, 1'b0); // Unwritten registers read zero.
        addRow(rType(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd2, b, 32'h0, 5'd0, NO, 1'b0);
        addRow(rType(FN_SUBU, 5'd1, 5'd2, 5'd3, 5'd0), 1'b0, 5'd0, 32'h0, a + b, 5'd3, WR, 1'b0);
        addRow(rType(FN_AND, 5'd1, 5'd2, 5'd4, 5'd0), 1'b0, 5'd0, 32'h0, a - b, 5'd3, WR, 1'b0);
        addRow(rType(FN_OR, 5'd1, 5'd2, 5'd4, 5'd0), 1'b0, 5'd0, 32'h0, a & b, 5'd4, WR, 1'b0);
        addRow(rType(FN_XOR, 5'd1, 5'd2, 5'd6, 5'd0), 1'b0, 5'd0, 32'h0, a | b, 5'd4, WR, 1'b0);
        addRow(rType(FN_SLT, 5'd1, 5'd2, 5'd8, 5'd0), 1'b0, 5'd0, 32'h0, a ^ b, 5'd6, WR, 1'b0);
        addRow(rType(FN_SLL, 5'd0, 5'd1, 5'd9, 5'd7), 1'b0, 5'd0, 32'h0, signedLess(a, b),
            5'd8, WR, 1'b0);
        addRow(rType(FN_SRL, 5'd0, 5'd2, 5'd10, 5'd13), 1'b0, 5'd0, 32'h0, a << 7, 5'd9, WR, 1'b0);
        addRow(iType(OP_ADDIU, 5'd1, 5'd11, 16'h8005), 1'b0, 5'd0, 32'h0, b >> 13, 5'd10, WR, 1'b0);
        addRow(iType(OP_SLTI, 5'd1, 5'd12, 16'hFFF0), 1'b0, 5'd0, 32'h0, a + 32'hFFFF_8005,
            5'd11, WR, 1'b0);
        addRow(iType(OP_ANDI, 5'd2, 5'd13, 16'hF0F0), 1'b0, 5'd0, 32'h0,
            signedLess(a, 32'hFFFF_FFF0), 5'd12, WR, 1'b0);
        addRow(iType(OP_ORI, 5'd2, 5'd14, 16'h8001), 1'b0, 5'd0, 32'h0, b & 32'h0000_F0F0,
            5'd13, WR, 1'b0);
        addRow(iType(OP_LUI, 5'd0, 5'd15, 16'hBEEF), 1'b0, 5'd0, 32'h0, b | 32'h0000_8001,
            5'd14, WR, 1'b0);
        addRow(iType(OP_SW, 5'd1, 5'd2, 16'h0010), 1'b0, 5'd0, 32'h0, 32'hBEEF_0000,
            5'd15, WR, 1'b0);
        addRow(rType(FN_ADDU, 5'd1, 5'd2, 5'd17, 5'd0), 1'b0, 5'd0, 32'h0, a + 32'h10,
            5'd2, ST, 1'b0);
        expectStore(b);
        addRow(rType(FN_XOR, 5'd1, 5'd2, 5'd18, 5'd0), 1'b1, 5'd1, c, c + b, 5'd17, WR, 1'b0);
        addRow(rType(FN_ADDU, 5'd0, 5'd0, 5'd19, 5'd0), 1'b1, 5'd2, d, c ^ d, 5'd18, WR, 1'b0);
        addRow(iType(OP_LW, 5'd2, 5'd20, 16'h0004), 1'b1, 5'd0, d, 32'h0, 5'd19, WR, 1'b0);
        addRow(rType(FN_ADDU, 5'd20, 5'd1, 5'd21, 5'd0), 1'b0, 5'd0, 32'h0, d + 32'h4,
            5'd20, LD, 1'b1);
        addRow(rType(FN_ADDU, 5'd20, 5'd1, 5'd21, 5'd0), 1'b1, 5'd20, e, 32'h0, 5'd0, NO, 1'b0);
        addRow(iType(OP_LW, 5'd1, 5'd22, 16'h0000), 1'b0, 5'd0, 32'h0, e + c, 5'd21, WR, 1'b0);
        addRow(rType(FN_SUBU, 5'd1, 5'd22, 5'd23, 5'd0), 1'b0, 5'd0, 32'h0, c, 5'd22, LD, 1'b1);
        addRow(rType(FN_SUBU, 5'd1, 5'd22, 5'd23, 5'd0), 1'b0, 5'd0, 32'h0, 32'h0, 5'd0, NO, 1'b0);
        addRow(NOP, 1'b1, 5'd22, f, c - f, 5'd23, WR, 1'b0); // Load data forwarded into rt.
        addRow(NOP, 1'b0, 5'd0, 32'h0, 32'h0, 5'd0, NO, 1'b0);
    endtask

    initial
    begin
        clk     = 1'b0;
        reset   = 1'b1;
        instr   = NOP;
        wbWrite = 1'b0;
        wbReg   = '0;
        wbData  = '0;
        void'($urandom(43));
        a = $urandom();
        b = $urandom();
        c = $urandom();
        d = $urandom();
        e = $urandom();
        f = $urandom();
        buildTable();
        assert (rowCount == NUM_ROWS)
        else
            failRun("The stimulus table is not completely filled.");
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            if (!holdInstr)
                instr = rows[k].instr; // A stalled instruction stays in decode.
            wbWrite = rows[k].wbWrite;
            wbReg   = rows[k].wbReg;
            wbData  = rows[k].wbData;
            #5;
            checkValue(k, "aluResult", rows[k].expAlu, aluResult);
            checkValue(k, "writeReg", 32'(rows[k].expWriteReg), 32'(writeReg));
            checkValue(k, "regWrite", 32'(rows[k].expCtrl[2]), 32'(regWrite));
            checkValue(k, "memWrite", 32'(rows[k].expCtrl[1]), 32'(memWrite));
            checkValue(k, "memToReg", 32'(rows[k].expCtrl[0]), 32'(memToReg));
            checkValue(k, "stall", 32'(rows[k].expStall), 32'(stall));
            if (rows[k].checkStore)
                checkValue(k, "storeData", rows[k].expStore, storeData);
            holdInstr = stall;
            @(posedge clk);
            #1;
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: decodeExecute.f
+incdir+logic
logic/pipePkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/idExRegister.sv
logic/executeStage.sv
logic/decodeExecute.sv
testbench/decodeExecuteTb.sv

// File: Makefile
# Verilator build for the decode to execute slice.

VERILATOR ?= verilator
TOP       ?= decodeExecuteTb
FILELIST  ?= decodeExecute.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
SOURCES   := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The simulator exits with a failing status when the testbench calls $fatal.
sim: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
